//--- core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W = 4;

	// alu operation codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

	// supported major opcodes
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// one instruction word, five ways to read it
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm_11_0;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} i_fmt;
		struct packed {
			logic imm_12;
			logic [5:0] imm_10_5;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm_31_12;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} u_fmt;
		struct packed {
			logic imm_20;
			logic [9:0] imm_10_1;
			logic imm_11;
			logic [7:0] imm_19_12;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_u;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none

module fetch_unit #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input wire clock,
	input wire reset,
	input wire imem_ready_i,
	input wire [core_pkg::XLEN-1:0] imem_rdata_i,
	input wire redirect_valid_i,
	input wire [core_pkg::XLEN-1:0] redirect_pc_i,
	output logic imem_valid_o,
	output logic [core_pkg::XLEN-1:0] imem_addr_o,
	output logic fd_valid_o,
	output logic [core_pkg::XLEN-1:0] fd_pc_o,
	output logic [core_pkg::XLEN-1:0] fd_inst_o
);

	logic [core_pkg::XLEN-1:0] pc_q;
	logic req_q;
	logic wait_q;
	logic xfer;
	logic is_ctrl;
	core_pkg::inst_u word;

	assign word = imem_rdata_i;
	assign xfer = req_q & imem_ready_i;

	// pre-decode, only the opcode matters here
	always_comb begin
		case (word.r_fmt.opcode)
			core_pkg::OPC_JAL,
			core_pkg::OPC_JALR,
			core_pkg::OPC_BRANCH: is_ctrl = 1'b1;
			default: is_ctrl = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= RESET_PC;
			req_q <= 1'b0;
			wait_q <= 1'b0;
		end else if (wait_q) begin
			// parked until execute resolves the jump or branch
			if (redirect_valid_i) begin
				pc_q <= redirect_pc_i;
				req_q <= 1'b1;
				wait_q <= 1'b0;
			end
		end else if (xfer) begin
			if (is_ctrl) begin
				req_q <= 1'b0;
				wait_q <= 1'b1;
			end else begin
				pc_q <= pc_q + core_pkg::XLEN'(4);
			end
		end else begin
			req_q <= 1'b1;
		end
	end

	assign imem_valid_o = req_q;
	assign imem_addr_o = pc_q;

	// word goes to decode in the transfer cycle
	assign fd_valid_o = xfer;
	assign fd_pc_o = pc_q;
	assign fd_inst_o = imem_rdata_i;

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

module decode_stage (
	input wire clock,
	input wire reset,
	input wire fd_valid_i,
	input wire [core_pkg::XLEN-1:0] fd_pc_i,
	input wire [core_pkg::XLEN-1:0] fd_inst_i,
	input wire [core_pkg::XLEN-1:0] rs1_data_i,
	input wire [core_pkg::XLEN-1:0] rs2_data_i,
	input wire ex_fwd_wen_i,
	input wire [core_pkg::REG_ADDR_W-1:0] ex_fwd_rd_i,
	input wire [core_pkg::XLEN-1:0] ex_fwd_data_i,
	input wire wb_wen_i,
	input wire [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input wire [core_pkg::XLEN-1:0] wb_data_i,
	output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
	output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
	output logic de_valid_o,
	output logic [core_pkg::XLEN-1:0] de_pc_o,
	output logic [core_pkg::XLEN-1:0] de_src1_o,
	output logic [core_pkg::XLEN-1:0] de_src2_o,
	output logic [core_pkg::XLEN-1:0] de_imm_o,
	output logic [core_pkg::ALU_OP_W-1:0] de_alu_op_o,
	output logic de_use_imm_o,
	output logic de_use_pc_o,
	output logic de_is_branch_o,
	output logic de_is_jal_o,
	output logic de_is_jalr_o,
	output logic [2:0] de_funct3_o,
	output logic [core_pkg::REG_ADDR_W-1:0] de_rd_o,
	output logic de_rd_wen_o
);

	logic fd_valid_q;
	logic [core_pkg::XLEN-1:0] fd_pc_q;
	core_pkg::inst_u inst_q;
	logic [core_pkg::XLEN-1:0] imm_i;
	logic [core_pkg::XLEN-1:0] imm_b;
	logic [core_pkg::XLEN-1:0] imm_u;
	logic [core_pkg::XLEN-1:0] imm_j;

	// funct3 to alu op, alt selects sub and sra
	function automatic logic [core_pkg::ALU_OP_W-1:0] alu_op_of(
		input logic [2:0] f3,
		input logic alt,
		input logic reg_op
	);
		logic [core_pkg::ALU_OP_W-1:0] op;
		case (f3)
			3'b000: op = (alt && reg_op) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'b001: op = core_pkg::ALU_SLL;
			3'b010: op = core_pkg::ALU_SLT;
			3'b011: op = core_pkg::ALU_SLTU;
			3'b100: op = core_pkg::ALU_XOR;
			3'b101: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'b110: op = core_pkg::ALU_OR;
			default: op = core_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	// execute beats writeback, writeback beats the register file
	function automatic logic [core_pkg::XLEN-1:0] operand(
		input logic [core_pkg::REG_ADDR_W-1:0] addr,
		input logic [core_pkg::XLEN-1:0] rf_data
	);
		logic [core_pkg::XLEN-1:0] val;
		if (addr == '0)
			val = '0;
		else if (ex_fwd_wen_i && ex_fwd_rd_i == addr)
			val = ex_fwd_data_i;
		else if (wb_wen_i && wb_rd_i == addr)
			val = wb_data_i;
		else
			val = rf_data;
		return val;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			fd_valid_q <= 1'b0;
		end else begin
			fd_valid_q <= fd_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (fd_valid_i) begin
			fd_pc_q <= fd_pc_i;
			inst_q <= fd_inst_i;
		end
	end

	assign imm_i = {{20{inst_q.i_fmt.imm_11_0[11]}}, inst_q.i_fmt.imm_11_0};
	assign imm_b = {{19{inst_q.b_fmt.imm_12}}, inst_q.b_fmt.imm_12, inst_q.b_fmt.imm_11,
		inst_q.b_fmt.imm_10_5, inst_q.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {inst_q.u_fmt.imm_31_12, 12'b0};
	assign imm_j = {{11{inst_q.j_fmt.imm_20}}, inst_q.j_fmt.imm_20, inst_q.j_fmt.imm_19_12,
		inst_q.j_fmt.imm_11, inst_q.j_fmt.imm_10_1, 1'b0};

	assign rs1_addr_o = inst_q.r_fmt.rs1;
	assign rs2_addr_o = inst_q.r_fmt.rs2;

	always_comb begin
		de_imm_o = imm_i;
		de_alu_op_o = core_pkg::ALU_ADD;
		de_use_imm_o = 1'b0;
		de_use_pc_o = 1'b0;
		de_is_branch_o = 1'b0;
		de_is_jal_o = 1'b0;
		de_is_jalr_o = 1'b0;
		de_rd_wen_o = 1'b0;
		case (inst_q.r_fmt.opcode)
			core_pkg::OPC_OP: begin
				de_alu_op_o = alu_op_of(inst_q.r_fmt.funct3, inst_q.r_fmt.funct7[5], 1'b1);
				de_rd_wen_o = 1'b1;
			end
			core_pkg::OPC_OP_IMM: begin
				de_alu_op_o = alu_op_of(inst_q.r_fmt.funct3, inst_q.r_fmt.funct7[5], 1'b0);
				de_use_imm_o = 1'b1;
				de_rd_wen_o = 1'b1;
			end
			core_pkg::OPC_LUI: begin
				de_imm_o = imm_u;
				de_alu_op_o = core_pkg::ALU_PASS_B;
				de_use_imm_o = 1'b1;
				de_rd_wen_o = 1'b1;
			end
			core_pkg::OPC_AUIPC: begin
				de_imm_o = imm_u;
				de_use_imm_o = 1'b1;
				de_use_pc_o = 1'b1;
				de_rd_wen_o = 1'b1;
			end
			core_pkg::OPC_JAL: begin
				de_imm_o = imm_j;
				de_is_jal_o = 1'b1;
				de_rd_wen_o = 1'b1;
			end
			core_pkg::OPC_JALR: begin
				de_is_jalr_o = 1'b1;
				de_rd_wen_o = 1'b1;
			end
			core_pkg::OPC_BRANCH: begin
				de_imm_o = imm_b;
				de_is_branch_o = 1'b1;
			end
			// unsupported opcode passes through as a no-op
			default: de_rd_wen_o = 1'b0;
		endcase
	end

	always_comb begin
		de_src1_o = operand(rs1_addr_o, rs1_data_i);
		de_src2_o = operand(rs2_addr_o, rs2_data_i);
	end

	assign de_valid_o = fd_valid_q;
	assign de_pc_o = fd_pc_q;
	assign de_funct3_o = inst_q.r_fmt.funct3;
	assign de_rd_o = inst_q.r_fmt.rd;

endmodule

`default_nettype wire

//--- regfile.sv
`default_nettype none

module regfile (
	input wire clock,
	input wire reset,
	input wire [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
	input wire [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
	input wire wen_i,
	input wire [core_pkg::REG_ADDR_W-1:0] rd_addr_i,
	input wire [core_pkg::XLEN-1:0] rd_data_i,
	output logic [core_pkg::XLEN-1:0] rs1_data_o,
	output logic [core_pkg::XLEN-1:0] rs2_data_o
);

	// x0 has no storage
	logic [core_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && rd_addr_i != '0) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

module execute_stage (
	input wire clock,
	input wire reset,
	input wire de_valid_i,
	input wire [core_pkg::XLEN-1:0] de_pc_i,
	input wire [core_pkg::XLEN-1:0] de_src1_i,
	input wire [core_pkg::XLEN-1:0] de_src2_i,
	input wire [core_pkg::XLEN-1:0] de_imm_i,
	input wire [core_pkg::ALU_OP_W-1:0] de_alu_op_i,
	input wire de_use_imm_i,
	input wire de_use_pc_i,
	input wire de_is_branch_i,
	input wire de_is_jal_i,
	input wire de_is_jalr_i,
	input wire [2:0] de_funct3_i,
	input wire [core_pkg::REG_ADDR_W-1:0] de_rd_i,
	input wire de_rd_wen_i,
	output logic ex_fwd_wen_o,
	output logic [core_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o,
	output logic [core_pkg::XLEN-1:0] ex_fwd_data_o,
	output logic redirect_valid_o,
	output logic [core_pkg::XLEN-1:0] redirect_pc_o,
	output logic ew_valid_o,
	output logic [core_pkg::XLEN-1:0] ew_pc_o,
	output logic [core_pkg::REG_ADDR_W-1:0] ew_rd_o,
	output logic ew_rd_wen_o,
	output logic [core_pkg::XLEN-1:0] ew_result_o
);

	logic valid_q;
	logic [core_pkg::XLEN-1:0] pc_q;
	logic [core_pkg::XLEN-1:0] src1_q;
	logic [core_pkg::XLEN-1:0] src2_q;
	logic [core_pkg::XLEN-1:0] imm_q;
	logic [core_pkg::ALU_OP_W-1:0] alu_op_q;
	logic use_imm_q;
	logic use_pc_q;
	logic is_branch_q;
	logic is_jal_q;
	logic is_jalr_q;
	logic [2:0] funct3_q;
	logic [core_pkg::REG_ADDR_W-1:0] rd_q;
	logic rd_wen_q;

	logic [core_pkg::XLEN-1:0] op_a;
	logic [core_pkg::XLEN-1:0] op_b;
	logic [core_pkg::XLEN-1:0] alu_out;
	logic [core_pkg::XLEN-1:0] pc_plus4;
	logic [core_pkg::XLEN-1:0] target;
	logic [core_pkg::XLEN-1:0] result;
	logic cond;
	logic taken;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= de_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		pc_q <= de_pc_i;
		src1_q <= de_src1_i;
		src2_q <= de_src2_i;
		imm_q <= de_imm_i;
		alu_op_q <= de_alu_op_i;
		use_imm_q <= de_use_imm_i;
		use_pc_q <= de_use_pc_i;
		is_branch_q <= de_is_branch_i;
		is_jal_q <= de_is_jal_i;
		is_jalr_q <= de_is_jalr_i;
		funct3_q <= de_funct3_i;
		rd_q <= de_rd_i;
		rd_wen_q <= de_rd_wen_i;
	end

	assign op_a = use_pc_q ? pc_q : src1_q;
	assign op_b = use_imm_q ? imm_q : src2_q;

	always_comb begin
		case (alu_op_q)
			core_pkg::ALU_SUB: alu_out = op_a - op_b;
			core_pkg::ALU_SLL: alu_out = op_a << op_b[4:0];
			core_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			core_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
			core_pkg::ALU_XOR: alu_out = op_a ^ op_b;
			core_pkg::ALU_SRL: alu_out = op_a >> op_b[4:0];
			core_pkg::ALU_SRA: alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
			core_pkg::ALU_OR: alu_out = op_a | op_b;
			core_pkg::ALU_AND: alu_out = op_a & op_b;
			core_pkg::ALU_PASS_B: alu_out = op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	// branch compare always on the register operands
	always_comb begin
		case (funct3_q)
			3'b000: cond = src1_q == src2_q;
			3'b001: cond = src1_q != src2_q;
			3'b100: cond = $signed(src1_q) < $signed(src2_q);
			3'b101: cond = $signed(src1_q) >= $signed(src2_q);
			3'b110: cond = src1_q < src2_q;
			3'b111: cond = src1_q >= src2_q;
			default: cond = 1'b0;
		endcase
	end

	assign pc_plus4 = pc_q + core_pkg::XLEN'(4);
	assign target = is_jalr_q ? ((src1_q + imm_q) & ~core_pkg::XLEN'(1)) : (pc_q + imm_q);
	assign taken = is_jal_q | is_jalr_q | (is_branch_q & cond);
	assign result = (is_jal_q | is_jalr_q) ? pc_plus4 : alu_out;

	assign redirect_valid_o = valid_q & (is_branch_q | is_jal_q | is_jalr_q);
	assign redirect_pc_o = taken ? target : pc_plus4;

	assign ex_fwd_wen_o = valid_q & rd_wen_q;
	assign ex_fwd_rd_o = rd_q;
	assign ex_fwd_data_o = result;

	assign ew_valid_o = valid_q;
	assign ew_pc_o = pc_q;
	assign ew_rd_o = rd_q;
	assign ew_rd_wen_o = rd_wen_q;
	assign ew_result_o = result;

endmodule

`default_nettype wire

//--- writeback_stage.sv
`default_nettype none

module writeback_stage (
	input wire clock,
	input wire reset,
	input wire ew_valid_i,
	input wire [core_pkg::XLEN-1:0] ew_pc_i,
	input wire [core_pkg::REG_ADDR_W-1:0] ew_rd_i,
	input wire ew_rd_wen_i,
	input wire [core_pkg::XLEN-1:0] ew_result_i,
	output logic wb_wen_o,
	output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [core_pkg::XLEN-1:0] wb_data_o,
	output logic commit_valid_o,
	output logic [core_pkg::XLEN-1:0] commit_pc_o,
	output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
	output logic commit_wen_o,
	output logic [core_pkg::XLEN-1:0] commit_data_o
);

	logic valid_q;
	logic [core_pkg::XLEN-1:0] pc_q;
	logic [core_pkg::REG_ADDR_W-1:0] rd_q;
	logic rd_wen_q;
	logic [core_pkg::XLEN-1:0] result_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= ew_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		pc_q <= ew_pc_i;
		rd_q <= ew_rd_i;
		rd_wen_q <= ew_rd_wen_i;
		result_q <= ew_result_i;
	end

	// x0 writes retire but never reach the register file
	assign wb_wen_o = valid_q & rd_wen_q & (rd_q != '0);
	assign wb_rd_o = rd_q;
	assign wb_data_o = result_q;

	assign commit_valid_o = valid_q;
	assign commit_pc_o = pc_q;
	assign commit_rd_o = rd_q;
	assign commit_wen_o = rd_wen_q;
	assign commit_data_o = result_q;

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core #(
	parameter logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input wire clock,
	input wire reset,
	input wire imem_ready_i,
	input wire [core_pkg::XLEN-1:0] imem_rdata_i,
	output logic imem_valid_o,
	output logic [core_pkg::XLEN-1:0] imem_addr_o,
	output logic commit_valid_o,
	output logic [core_pkg::XLEN-1:0] commit_pc_o,
	output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
	output logic commit_wen_o,
	output logic [core_pkg::XLEN-1:0] commit_data_o
);

	// fetch to decode
	logic fd_valid;
	logic [core_pkg::XLEN-1:0] fd_pc;
	logic [core_pkg::XLEN-1:0] fd_inst;

	// register file read side
	logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
	logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
	logic [core_pkg::XLEN-1:0] rs1_data;
	logic [core_pkg::XLEN-1:0] rs2_data;

	// decode to execute
	logic de_valid;
	logic [core_pkg::XLEN-1:0] de_pc;
	logic [core_pkg::XLEN-1:0] de_src1;
	logic [core_pkg::XLEN-1:0] de_src2;
	logic [core_pkg::XLEN-1:0] de_imm;
	logic [core_pkg::ALU_OP_W-1:0] de_alu_op;
	logic de_use_imm;
	logic de_use_pc;
	logic de_is_branch;
	logic de_is_jal;
	logic de_is_jalr;
	logic [2:0] de_funct3;
	logic [core_pkg::REG_ADDR_W-1:0] de_rd;
	logic de_rd_wen;

	// forwarding and redirect
	logic ex_fwd_wen;
	logic [core_pkg::REG_ADDR_W-1:0] ex_fwd_rd;
	logic [core_pkg::XLEN-1:0] ex_fwd_data;
	logic redirect_valid;
	logic [core_pkg::XLEN-1:0] redirect_pc;

	// execute to writeback
	logic ew_valid;
	logic [core_pkg::XLEN-1:0] ew_pc;
	logic [core_pkg::REG_ADDR_W-1:0] ew_rd;
	logic ew_rd_wen;
	logic [core_pkg::XLEN-1:0] ew_result;

	// register write, also forwarded
	logic wb_wen;
	logic [core_pkg::REG_ADDR_W-1:0] wb_rd;
	logic [core_pkg::XLEN-1:0] wb_data;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) fetch0 (
		.clock(clock),
		.reset(reset),
		.imem_ready_i(imem_ready_i),
		.imem_rdata_i(imem_rdata_i),
		.redirect_valid_i(redirect_valid),
		.redirect_pc_i(redirect_pc),
		.imem_valid_o(imem_valid_o),
		.imem_addr_o(imem_addr_o),
		.fd_valid_o(fd_valid),
		.fd_pc_o(fd_pc),
		.fd_inst_o(fd_inst)
	);

	decode_stage decode0 (
		.clock(clock),
		.reset(reset),
		.fd_valid_i(fd_valid),
		.fd_pc_i(fd_pc),
		.fd_inst_i(fd_inst),
		.rs1_data_i(rs1_data),
		.rs2_data_i(rs2_data),
		.ex_fwd_wen_i(ex_fwd_wen),
		.ex_fwd_rd_i(ex_fwd_rd),
		.ex_fwd_data_i(ex_fwd_data),
		.wb_wen_i(wb_wen),
		.wb_rd_i(wb_rd),
		.wb_data_i(wb_data),
		.rs1_addr_o(rs1_addr),
		.rs2_addr_o(rs2_addr),
		.de_valid_o(de_valid),
		.de_pc_o(de_pc),
		.de_src1_o(de_src1),
		.de_src2_o(de_src2),
		.de_imm_o(de_imm),
		.de_alu_op_o(de_alu_op),
		.de_use_imm_o(de_use_imm),
		.de_use_pc_o(de_use_pc),
		.de_is_branch_o(de_is_branch),
		.de_is_jal_o(de_is_jal),
		.de_is_jalr_o(de_is_jalr),
		.de_funct3_o(de_funct3),
		.de_rd_o(de_rd),
		.de_rd_wen_o(de_rd_wen)
	);

	regfile regfile0 (
		.clock(clock),
		.reset(reset),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.wen_i(wb_wen),
		.rd_addr_i(wb_rd),
		.rd_data_i(wb_data),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data)
	);

	execute_stage execute0 (
		.clock(clock),
		.reset(reset),
		.de_valid_i(de_valid),
		.de_pc_i(de_pc),
		.de_src1_i(de_src1),
		.de_src2_i(de_src2),
		.de_imm_i(de_imm),
		.de_alu_op_i(de_alu_op),
		.de_use_imm_i(de_use_imm),
		.de_use_pc_i(de_use_pc),
		.de_is_branch_i(de_is_branch),
		.de_is_jal_i(de_is_jal),
		.de_is_jalr_i(de_is_jalr),
		.de_funct3_i(de_funct3),
		.de_rd_i(de_rd),
		.de_rd_wen_i(de_rd_wen),
		.ex_fwd_wen_o(ex_fwd_wen),
		.ex_fwd_rd_o(ex_fwd_rd),
		.ex_fwd_data_o(ex_fwd_data),
		.redirect_valid_o(redirect_valid),
		.redirect_pc_o(redirect_pc),
		.ew_valid_o(ew_valid),
		.ew_pc_o(ew_pc),
		.ew_rd_o(ew_rd),
		.ew_rd_wen_o(ew_rd_wen),
		.ew_result_o(ew_result)
	);

	writeback_stage writeback0 (
		.clock(clock),
		.reset(reset),
		.ew_valid_i(ew_valid),
		.ew_pc_i(ew_pc),
		.ew_rd_i(ew_rd),
		.ew_rd_wen_i(ew_rd_wen),
		.ew_result_i(ew_result),
		.wb_wen_o(wb_wen),
		.wb_rd_o(wb_rd),
		.wb_data_o(wb_data),
		.commit_valid_o(commit_valid_o),
		.commit_pc_o(commit_pc_o),
		.commit_rd_o(commit_rd_o),
		.commit_wen_o(commit_wen_o),
		.commit_data_o(commit_data_o)
	);

endmodule

`default_nettype wire

//--- tb_program.svh
// place_at: address, instruction word (only reached on a wrong path)
// expect_at: name, address, instruction word, rd, rd written, result
task automatic build_program();
	// immediate and register alu, back-to-back dependencies
	expect_at("addi x1 x0 5", 'h100, imm_op(0, 1, 0, 5), 1, 1, 'h5);
	expect_at("addi x2 x0 -3", 'h104, imm_op(0, 2, 0, -3), 2, 1, 'hffff_fffd);
	expect_at("add x3 x1 x2", 'h108, reg_op('h00, 0, 3, 1, 2), 3, 1, 'h2);
	expect_at("sub x4 x1 x2", 'h10c, reg_op('h20, 0, 4, 1, 2), 4, 1, 'h8);
	expect_at("slli x5 x1 3", 'h110, imm_op(1, 5, 1, 3), 5, 1, 'h28);
	expect_at("srli x6 x2 4", 'h114, imm_op(5, 6, 2, 4), 6, 1, 'h0fff_ffff);
	expect_at("srai x7 x2 1", 'h118, imm_op(5, 7, 2, 'h401), 7, 1, 'hffff_fffe);
	expect_at("slt x8 x2 x1", 'h11c, reg_op('h00, 2, 8, 2, 1), 8, 1, 'h1);
	expect_at("sltu x9 x2 x1", 'h120, reg_op('h00, 3, 9, 2, 1), 9, 1, 'h0);
	expect_at("xori x10 x1 0xff", 'h124, imm_op(4, 10, 1, 'hff), 10, 1, 'hfa);
	expect_at("or x11 x10 x1", 'h128, reg_op('h00, 6, 11, 10, 1), 11, 1, 'hff);
	expect_at("and x12 x11 x6", 'h12c, reg_op('h00, 7, 12, 11, 6), 12, 1, 'hff);
	expect_at("sll x13 x1 x3", 'h130, reg_op('h00, 1, 13, 1, 3), 13, 1, 'h14);
	expect_at("srl x14 x2 x3", 'h134, reg_op('h00, 5, 14, 2, 3), 14, 1, 'h3fff_ffff);
	expect_at("sra x15 x2 x3", 'h138, reg_op('h20, 5, 15, 2, 3), 15, 1, 'hffff_ffff);
	expect_at("slti x16 x2 -2", 'h13c, imm_op(2, 16, 2, -2), 16, 1, 'h1);
	expect_at("sltiu x17 x1 -1", 'h140, imm_op(3, 17, 1, -1), 17, 1, 'h1);
	expect_at("xor x18 x15 x1", 'h144, reg_op('h00, 4, 18, 15, 1), 18, 1, 'hffff_fffa);
	expect_at("andi x19 x18 0xf0", 'h148, imm_op(7, 19, 18, 'hf0), 19, 1, 'hf0);
	expect_at("ori x20 x19 0x0f", 'h14c, imm_op(6, 20, 19, 'h0f), 20, 1, 'hff);
	// upper immediates and x0
	expect_at("lui x21", 'h150, upper('h37, 21, 'h12345), 21, 1, 'h1234_5000);
	expect_at("auipc x22", 'h154, upper('h17, 22, 'h1), 22, 1, 'h1154);
	expect_at("addi x0 x1 7", 'h158, imm_op(0, 0, 1, 7), 0, 1, 'hc);
	expect_at("add x23 x0 x1", 'h15c, reg_op('h00, 0, 23, 0, 1), 23, 1, 'h5);
	// each branch kind taken and not taken
	expect_at("beq taken", 'h160, branch(0, 1, 23, 8), 0, 0, 0);
	place_at('h164, imm_op(0, 31, 0, 1));
	expect_at("beq not taken", 'h168, branch(0, 1, 2, 8), 0, 0, 0);
	expect_at("bne taken", 'h16c, branch(1, 1, 2, 8), 0, 0, 0);
	place_at('h170, imm_op(0, 31, 0, 1));
	expect_at("bne not taken", 'h174, branch(1, 1, 23, 8), 0, 0, 0);
	expect_at("blt taken", 'h178, branch(4, 2, 1, 8), 0, 0, 0);
	place_at('h17c, imm_op(0, 31, 0, 1));
	expect_at("blt not taken", 'h180, branch(4, 1, 2, 8), 0, 0, 0);
	expect_at("bge taken", 'h184, branch(5, 1, 2, 8), 0, 0, 0);
	place_at('h188, imm_op(0, 31, 0, 1));
	expect_at("bge not taken", 'h18c, branch(5, 2, 1, 8), 0, 0, 0);
	expect_at("bltu taken", 'h190, branch(6, 1, 2, 8), 0, 0, 0);
	place_at('h194, imm_op(0, 31, 0, 1));
	expect_at("bltu not taken", 'h198, branch(6, 2, 1, 8), 0, 0, 0);
	expect_at("bgeu taken", 'h19c, branch(7, 2, 1, 8), 0, 0, 0);
	place_at('h1a0, imm_op(0, 31, 0, 1));
	expect_at("bgeu not taken", 'h1a4, branch(7, 1, 2, 8), 0, 0, 0);
	// branch operand straight from execute
	expect_at("addi x24 x0 -3", 'h1a8, imm_op(0, 24, 0, -3), 24, 1, 'hffff_fffd);
	expect_at("beq x24 x2 fwd", 'h1ac, branch(0, 24, 2, 12), 0, 0, 0);
	place_at('h1b0, imm_op(0, 31, 0, 1));
	place_at('h1b4, imm_op(0, 31, 0, 1));
	// jumps
	expect_at("jal x25 +16", 'h1b8, jal(25, 16), 25, 1, 'h1bc);
	place_at('h1bc, imm_op(0, 31, 0, 1));
	expect_at("addi x26 x25 0x21", 'h1c8, imm_op(0, 26, 25, 'h21), 26, 1, 'h1dd);
	expect_at("jalr x27 x26 4", 'h1cc, jalr(27, 26, 4), 27, 1, 'h1d0);
	place_at('h1d0, imm_op(0, 31, 0, 1));
	expect_at("addi x28 x27 0", 'h1e0, imm_op(0, 28, 27, 0), 28, 1, 'h1d0);
	expect_at("jal x0 +8", 'h1e4, jal(0, 8), 0, 1, 'h1e8);
	place_at('h1e8, imm_op(0, 31, 0, 1));
	expect_at("add x29 x28 x0", 'h1ec, reg_op('h00, 0, 29, 28, 0), 29, 1, 'h1d0);
	expect_at("jal x30 +0x20", 'h1f0, jal(30, 'h20), 30, 1, 'h1f4);
	expect_at("beq backward", 'h210, branch(0, 0, 0, -24), 0, 0, 0);
	place_at('h214, imm_op(0, 31, 0, 1));
	expect_at("addi x31 x0 -1", 'h1f8, imm_op(0, 31, 0, -1), 31, 1, 'hffff_ffff);
endtask

//--- tb_rv_core.sv
`default_nettype none

module tb_rv_core;

	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam int WAIT_LIMIT = 200;

	logic clock;
	logic reset;
	logic imem_ready;
	logic [31:0] imem_rdata;
	logic imem_valid;
	logic [31:0] imem_addr;
	logic commit_valid;
	logic [31:0] commit_pc;
	logic [4:0] commit_rd;
	logic commit_wen;
	logic [31:0] commit_data;

	integer seed;
	logic [31:0] imem [bit [31:0]];
	string exp_name [$];
	logic [31:0] exp_pc [$];
	logic [4:0] exp_rd [$];
	logic exp_wen [$];
	logic [31:0] exp_data [$];

	rv_core #(
		.RESET_PC(RESET_PC)
	) dut0 (
		.clock(clock),
		.reset(reset),
		.imem_ready_i(imem_ready),
		.imem_rdata_i(imem_rdata),
		.imem_valid_o(imem_valid),
		.imem_addr_o(imem_addr),
		.commit_valid_o(commit_valid),
		.commit_pc_o(commit_pc),
		.commit_rd_o(commit_rd),
		.commit_wen_o(commit_wen),
		.commit_data_o(commit_data)
	);

	// rv32i encodings
	function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] imm_op(input int f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
	endfunction

	function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] upper(input int opc, input int rd, input int imm);
		return {imm[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] jal(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h67};
	endfunction

	task automatic place_at(input logic [31:0] addr, input logic [31:0] word);
		imem[addr] = word;
	endtask

	task automatic expect_at(input string name, input logic [31:0] addr,
		input logic [31:0] word, input int rd, input int wen, input logic [31:0] data);
		place_at(addr, word);
		exp_name.push_back(name);
		exp_pc.push_back(addr);
		exp_rd.push_back(rd[4:0]);
		exp_wen.push_back(wen != 0);
		exp_data.push_back(data);
	endtask

	`include "tb_program.svh"

	// unmapped words carry opcode 0 that the core does not support
	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (imem.exists(addr))
			return imem[addr];
		return {addr[31:7] ^ {18'b0, addr[6:0]}, 7'b0000000};
	endfunction

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			stop_with_error($sformatf("CHECK FAILED %s expected %h actual %h",
				name, expected, actual));
	endtask

	task automatic wait_commit(input string name);
		int n;
		n = 0;
		@(negedge clock);
		while (commit_valid !== 1'b1) begin
			if (n == WAIT_LIMIT)
				stop_with_error($sformatf("timed out waiting for the commit of %s", name));
			n++;
			@(negedge clock);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// memory model drives random ready and the word at the current address
	initial begin
		imem_ready = 1'b0;
		imem_rdata = '0;
		seed = 32'h1875;
		forever begin
			@(posedge clock);
			#1;
			imem_ready = ($random(seed) & 3) != 0;
			imem_rdata = fetch_word(imem_addr);
		end
	end

	initial begin
		int n;
		reset = 1'b1;
		build_program();
		repeat (4) begin
			@(posedge clock);
			#1;
			compare("imem_valid in reset", 32'd0, 32'(imem_valid));
			compare("commit_valid in reset", 32'd0, 32'(commit_valid));
		end
		reset = 1'b0;

		n = 0;
		while (imem_valid !== 1'b1) begin
			if (n == WAIT_LIMIT)
				stop_with_error("timed out waiting for the first fetch request");
			n++;
			@(negedge clock);
		end
		compare("first fetch address", RESET_PC, imem_addr);
		compare("commit_valid after reset", 32'd0, 32'(commit_valid));

		for (int i = 0; i < exp_pc.size(); i++) begin
			wait_commit(exp_name[i]);
			compare({exp_name[i], " pc"}, exp_pc[i], commit_pc);
			compare({exp_name[i], " wen"}, 32'(exp_wen[i]), 32'(commit_wen));
			// branches leave rd and data undefined
			if (exp_wen[i]) begin
				compare({exp_name[i], " rd"}, 32'(exp_rd[i]), 32'(commit_rd));
				compare({exp_name[i], " data"}, exp_data[i], commit_data);
			end
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
core_pkg.sv
fetch_unit.sv
decode_stage.sv
regfile.sv
execute_stage.sv
writeback_stage.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_rv_core -f src.f

sim:
	verilator --binary --timing --top-module tb_rv_core -f src.f -o tb_rv_core
	out=$$(./obj_dir/tb_rv_core 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
